// ==== build.f ====
+incdir+.
cart_pkg.sv
mem_pkg.sv
cart_if.sv
map_config.sv
discrete_mapper.sv
map_mux.sv
mem_channel.sv
cart_top.sv
tb_cart_top.sv

// ==== Makefile ====
# Verilator build and run for the cartridge mapper testbench

VERILATOR ?= verilator
TOP       ?= tb_cart_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_cart_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cart_defs.svh"

module tb_cart_top;
    import cart_pkg::*;

    // loads take 768 cycles and the tests well under 1000
    localparam int MAX_CYCLES = 20000;

    logic                      m2;
    logic                      async_reset;
    logic [15:0]               cpu_addr;
    logic [7:0]                cpu_data_in;
    logic [7:0]                cpu_data_out;
    logic                      cpu_rw;
    logic                      cpu_oe;
    logic [13:0]               ppu_addr;
    logic [7:0]                ppu_data_in;
    logic [7:0]                ppu_data_out;
    logic                      ppu_rd;
    logic                      ppu_wr;
    logic                      ppu_oe;
    logic                      irq;
    logic                      ciram_a10;
    logic                      ciram_ce;
    logic [31:0]               wr_reg;
    logic [3:0]                wr_reg_addr;
    logic                      wr_reg_changed;
    logic                      load_we;
    logic                      load_chr;
    logic [`PRG_ADDR_BITS-1:0] load_addr;
    logic [7:0]                load_data;

    // reference model of both memories and of the config state
    logic [7:0] prg_model [2**`PRG_ADDR_BITS];
    logic [7:0] chr_model [2**`CHR_ADDR_BITS];
    mapper_id_t sel_model;
    mirror_t    mirror_model;
    logic       cfg_busy;
    logic       cpu_chk;
    logic       ppu_chk;
    logic [7:0] cpu_exp;
    logic [7:0] ppu_exp;
    logic [31:0] rng;
    int         cycles;

    logic exp_cpu_oe;
    logic exp_ppu_oe;
    logic exp_ciram_ce;
    logic exp_ciram_a10;

    cart_top i_dut (.*);

    always #50 m2 = ~m2;

    always @(posedge m2) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not reach its end within %0d cycles", MAX_CYCLES);
            stop_run();
        end
    end

    //////////////////////////////////////////////////
    // expected strobes
    //////////////////////////////////////////////////

    assign exp_cpu_oe    = (sel_model != map_none) && cpu_rw && cpu_addr[15];
    assign exp_ppu_oe    = (sel_model != map_none) && ppu_rd && !ppu_addr[13];
    assign exp_ciram_ce  = (sel_model != map_none) && ppu_addr[13];
    assign exp_ciram_a10 = (mirror_model == mirror_vert) ? ppu_addr[10] : ppu_addr[11];

    a_cpu_oe: assert property (
        @(posedge m2) disable iff (async_reset || cfg_busy) cpu_oe == exp_cpu_oe
    ) else report_value("cpu_oe", 8'($sampled(exp_cpu_oe)), 8'($sampled(cpu_oe)));

    a_ppu_oe: assert property (
        @(posedge m2) disable iff (async_reset || cfg_busy) ppu_oe == exp_ppu_oe
    ) else report_value("ppu_oe", 8'($sampled(exp_ppu_oe)), 8'($sampled(ppu_oe)));

    a_ciram_ce: assert property (
        @(posedge m2) disable iff (async_reset || cfg_busy) ciram_ce == exp_ciram_ce
    ) else report_value("ciram_ce", 8'($sampled(exp_ciram_ce)), 8'($sampled(ciram_ce)));

    a_ciram_a10: assert property (
        @(posedge m2) disable iff (async_reset || cfg_busy)
            (sel_model != map_none) |-> ciram_a10 == exp_ciram_a10
    ) else report_value("ciram_a10", 8'($sampled(exp_ciram_a10)), 8'($sampled(ciram_a10)));

    a_irq: assert property (
        @(posedge m2) disable iff (async_reset) !irq
    ) else report_value("irq", 8'h00, 8'($sampled(irq)));

    // read data lands one edge after the address was sampled
    a_cpu_data: assert property (
        @(posedge m2) disable iff (async_reset) cpu_chk |-> cpu_data_out == cpu_exp
    ) else report_value("cpu_data_out", $sampled(cpu_exp), $sampled(cpu_data_out));

    a_ppu_data: assert property (
        @(posedge m2) disable iff (async_reset) ppu_chk |-> ppu_data_out == ppu_exp
    ) else report_value("ppu_data_out", $sampled(ppu_exp), $sampled(ppu_data_out));

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_value(input string name, input logic [7:0] exp,
                                input logic [7:0] act);
        $display("** Error: %s expected 0x%02h, got 0x%02h", name, exp, act);
        stop_run();
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // first 32 and last 32 bytes of a 16 KiB window
    function automatic logic [13:0] window_offset(input int i);
        if (i < 32) begin
            return 14'(i);
        end
        return 14'(16320 + i);
    endfunction

    task automatic next_edge();
        @(posedge m2);
        cpu_chk <= 1'b0;
        ppu_chk <= 1'b0;
    endtask

    task automatic load_byte(input logic is_chr, input logic [18:0] addr,
                             input logic [7:0] data);
        next_edge();
        load_we   <= 1'b1;
        load_chr  <= is_chr;
        load_addr <= addr;
        load_data <= data;
    endtask

    task automatic fill_memories();
        int          b;
        int          i;
        logic [13:0] off;
        for (b = 0; b < 8; b++) begin
            for (i = 0; i < 64; i++) begin
                off = window_offset(i);
                rng = xorshift(rng);
                load_byte(1'b0, {5'(b), off}, rng[7:0]);
                prg_model[{5'(b), off}] = rng[7:0];
            end
        end
        for (b = 0; b < 4; b++) begin
            for (i = 0; i < 64; i++) begin
                off = window_offset(i);
                rng = xorshift(rng);
                load_byte(1'b1, {4'd0, 2'(b), off[12:0]}, rng[7:0]);
                chr_model[{2'd0, 2'(b), off[12:0]}] = rng[7:0];
            end
        end
        next_edge();
        load_we <= 1'b0;
    endtask

    // config word with select in 1:0 and prg_log2 in 6:2 and mirror in 7
    task automatic set_config(input mapper_id_t sel, input logic [4:0] prg_log2,
                              input mirror_t mir);
        next_edge();
        wr_reg         <= {23'd0, 1'b0, mir, prg_log2, sel};
        wr_reg_addr    <= 4'd0;
        wr_reg_changed <= ~wr_reg_changed;
        cfg_busy       <= 1'b1;
        repeat (4) @(posedge m2);
        sel_model    <= sel;
        mirror_model <= mir;
        cfg_busy     <= 1'b0;
    endtask

    task automatic cpu_read(input logic [15:0] addr, input logic [7:0] exp);
        next_edge();
        cpu_addr <= addr;
        cpu_rw   <= 1'b1;
        @(posedge m2);
        cpu_chk <= 1'b1;
        cpu_exp <= exp;
    endtask

    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        next_edge();
        cpu_addr    <= addr;
        cpu_data_in <= data;
        cpu_rw      <= 1'b0;
        @(posedge m2);
        cpu_rw <= 1'b1;
    endtask

    task automatic ppu_read(input logic [13:0] addr, input logic [7:0] exp);
        next_edge();
        ppu_addr <= addr;
        ppu_rd   <= 1'b1;
        ppu_wr   <= 1'b0;
        @(posedge m2);
        ppu_chk <= 1'b1;
        ppu_exp <= exp;
    endtask

    task automatic ppu_write(input logic [13:0] addr, input logic [7:0] data);
        next_edge();
        ppu_addr    <= addr;
        ppu_data_in <= data;
        ppu_rd      <= 1'b0;
        ppu_wr      <= 1'b1;
        @(posedge m2);
        ppu_wr <= 1'b0;
        chr_model[{4'd0, addr[12:0]}] = data;
    endtask

    // random read-only bus traffic
    task automatic sweep_bus(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            next_edge();
            rng = xorshift(rng);
            cpu_addr <= rng[15:0];
            cpu_rw   <= 1'b1;
            ppu_addr <= rng[29:16];
            ppu_rd   <= rng[30];
            ppu_wr   <= 1'b0;
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        int          i;
        int          b;
        logic [13:0] off;
        logic [13:0] waddr [3];
        m2 = 1'b0;
        async_reset = 1'b1;
        cpu_addr = '0;
        cpu_data_in = '0;
        cpu_rw = 1'b1;
        ppu_addr = '0;
        ppu_data_in = '0;
        ppu_rd = 1'b0;
        ppu_wr = 1'b0;
        wr_reg = '0;
        wr_reg_addr = '0;
        wr_reg_changed = 1'b0;
        load_we = 1'b0;
        load_chr = 1'b0;
        load_addr = '0;
        load_data = '0;
        sel_model = map_none;
        mirror_model = mirror_horz;
        cfg_busy = 1'b0;
        cpu_chk = 1'b0;
        ppu_chk = 1'b0;
        cpu_exp = '0;
        ppu_exp = '0;
        rng = 32'd31;
        cycles = 0;
        waddr = '{14'h0123, 14'h1abc, 14'h0005};
        repeat (2) @(posedge m2);
        async_reset <= 1'b0;

        // no mapper selected while the memories fill
        fill_memories();
        sweep_bus(64);

        // NROM at 16 KiB where both halves mirror the same bank
        set_config(map_nrom, 5'd14, mirror_vert);
        for (i = 0; i < 64; i += 5) begin
            off = window_offset(i);
            cpu_read({2'b10, off}, prg_model[{5'd0, off}]);
            cpu_read({2'b11, off}, prg_model[{5'd0, off}]);
        end
        sweep_bus(32);

        // UxROM at 128 KiB with bank 7 in the upper window
        set_config(map_uxrom, 5'd17, mirror_horz);
        for (b = 3; b <= 5; b += 2) begin
            cpu_write(16'h8000, 8'(b));
            for (i = 0; i < 64; i += 5) begin
                off = window_offset(i);
                cpu_read({2'b10, off}, prg_model[{5'(b), off}]);
                cpu_read({2'b11, off}, prg_model[{5'd7, off}]);
            end
        end
        for (i = 0; i < 3; i++) begin
            rng = xorshift(rng);
            ppu_write(waddr[i], rng[7:0]);
            ppu_read(waddr[i], rng[7:0]);
        end
        sweep_bus(32);

        // CNROM with PRG unmasked
        set_config(map_cnrom, 5'd0, mirror_vert);
        for (b = 0; b < 4; b++) begin
            cpu_write(16'h8000, 8'(b));
            for (i = 0; i < 64; i += 5) begin
                off = window_offset(i);
                ppu_read({1'b0, off[12:0]}, chr_model[{2'd0, 2'(b), off[12:0]}]);
            end
        end
        sweep_bus(32);

        // back to UxROM whose bank register was held in reset
        set_config(map_uxrom, 5'd17, mirror_vert);
        for (i = 0; i < 64; i += 9) begin
            off = window_offset(i);
            cpu_read({2'b10, off}, prg_model[{5'd0, off}]);
        end
        sweep_bus(16);

        next_edge();
        next_edge();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cart_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cart_defs.svh"

module cart_top (
    input  logic                      m2,
    input  logic                      async_reset,
    input  logic [15:0]               cpu_addr,
    input  logic [7:0]                cpu_data_in,
    output logic [7:0]                cpu_data_out,
    input  logic                      cpu_rw,
    output logic                      cpu_oe,
    input  logic [13:0]               ppu_addr,
    input  logic [7:0]                ppu_data_in,
    output logic [7:0]                ppu_data_out,
    input  logic                      ppu_rd,
    input  logic                      ppu_wr,
    output logic                      ppu_oe,
    output logic                      irq,
    output logic                      ciram_a10,
    output logic                      ciram_ce,
    input  logic [31:0]               wr_reg,
    input  logic [3:0]                wr_reg_addr,
    input  logic                      wr_reg_changed,
    input  logic                      load_we,
    input  logic                      load_chr,
    input  logic [`PRG_ADDR_BITS-1:0] load_addr,
    input  logic [7:0]                load_data
);
    import cart_pkg::*;
    import mem_pkg::*;

    mapper_id_t select;
    map_args_t  args;
    load_req_t  load;

    map_bus                      slot [`MAP_CNT] ();
    mem_bus #(.addr_t(prg_addr_t)) prg_bus ();
    mem_bus #(.addr_t(chr_addr_t)) chr_bus ();

    assign load = '{we: load_we, chr: load_chr, addr: load_addr, data: load_data};

    map_config i_config (
        .m2(m2), .async_reset(async_reset), .wr_reg(wr_reg), .wr_reg_addr(wr_reg_addr),
        .wr_reg_changed(wr_reg_changed), .select(select), .args(args)
    );

    //////////////////////////////////////////////////
    // mapper bank with slot 0 left empty
    //////////////////////////////////////////////////

    discrete_mapper #(.kind(map_nrom))  i_nrom  (.m2(m2), .bus(slot[1]));
    discrete_mapper #(.kind(map_uxrom)) i_uxrom (.m2(m2), .bus(slot[2]));
    discrete_mapper #(.kind(map_cnrom)) i_cnrom (.m2(m2), .bus(slot[3]));

    map_mux i_mux (
        .select(select), .args(args), .cpu_addr(cpu_addr), .cpu_data_in(cpu_data_in),
        .cpu_rw(cpu_rw), .ppu_addr(ppu_addr), .ppu_data_in(ppu_data_in), .ppu_rd(ppu_rd),
        .ppu_wr(ppu_wr), .slot(slot), .prg(prg_bus), .chr(chr_bus), .cpu_oe(cpu_oe),
        .ppu_oe(ppu_oe), .irq(irq), .ciram_a10(ciram_a10), .ciram_ce(ciram_ce)
    );

    // memories
    mem_channel #(.addr_t(prg_addr_t), .is_chr(1'b0)) i_prg (
        .m2(m2), .load(load), .bus(prg_bus)
    );
    mem_channel #(.addr_t(chr_addr_t), .is_chr(1'b1)) i_chr (
        .m2(m2), .load(load), .bus(chr_bus)
    );

    assign cpu_data_out = prg_bus.rdata;
    assign ppu_data_out = chr_bus.rdata;

endmodule

`default_nettype wire

// ==== mem_channel.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_channel #(
    parameter type  addr_t = mem_pkg::prg_addr_t,
    parameter logic is_chr = 1'b0
) (
    input  logic                m2,
    input  mem_pkg::load_req_t  load,
    mem_bus.channel             bus
);
    localparam int AW = $bits(addr_t);

    logic [7:0] mem [2**AW];
    logic       load_hit;

    // the host shares one load port between both arrays
    assign load_hit = load.we && (load.chr == is_chr);

    //////////////////////////////////////////////////
    // write path
    //////////////////////////////////////////////////

    always_ff @(posedge m2) begin
        if (load_hit) begin
            mem[load.addr[AW-1:0]] <= load.data;
        end else if (bus.we) begin
            mem[bus.addr] <= bus.wdata;
        end
    end

    // registered read where data follows the address by one edge
    always_ff @(posedge m2) begin
        if (bus.oe) begin
            bus.rdata <= mem[bus.addr];
        end
    end

    // a write cycle never overlaps a read on the cart bus
    a_we_oe: assert property (
        @(posedge m2) !(bus.we && bus.oe)
    ) else $error("mem_channel: we and oe both high");

endmodule

`default_nettype wire

// ==== map_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cart_defs.svh"

module map_mux (
    input  cart_pkg::mapper_id_t select,
    input  cart_pkg::map_args_t  args,
    input  logic [15:0]          cpu_addr,
    input  logic [7:0]           cpu_data_in,
    input  logic                 cpu_rw,
    input  logic [13:0]          ppu_addr,
    input  logic [7:0]           ppu_data_in,
    input  logic                 ppu_rd,
    input  logic                 ppu_wr,
    map_bus.mux                  slot [`MAP_CNT],
    mem_bus.client               prg,
    mem_bus.client               chr,
    output logic                 cpu_oe,
    output logic                 ppu_oe,
    output logic                 irq,
    output logic                 ciram_a10,
    output logic                 ciram_ce
);
    import cart_pkg::*;
    import mem_pkg::*;

    prg_addr_t            prg_addr_v [`MAP_CNT];
    chr_addr_t            chr_addr_v [`MAP_CNT];
    logic [`MAP_CNT-1:0]  prg_oe_v;
    logic [`MAP_CNT-1:0]  chr_ce_v;
    logic [`MAP_CNT-1:0]  chr_oe_v;
    logic [`MAP_CNT-1:0]  chr_we_v;
    logic [`MAP_CNT-1:0]  ciram_a10_v;
    logic [`MAP_CNT-1:0]  ciram_ce_v;
    logic [`MAP_CNT-1:0]  irq_v;
    prg_addr_t            prg_mask;

    //////////////////////////////////////////////////
    // slot fan-out and unpacking
    //////////////////////////////////////////////////

    for (genvar n = 0; n < `MAP_CNT; n++) begin : g_slot
        // idle mappers stay in reset
        assign slot[n].reset       = (select != mapper_id_t'(n));
        assign slot[n].args        = args;
        assign slot[n].cpu_addr    = cpu_addr;
        assign slot[n].cpu_data_in = cpu_data_in;
        assign slot[n].cpu_rw      = cpu_rw;
        assign slot[n].ppu_addr    = ppu_addr;
        assign slot[n].ppu_rd      = ppu_rd;
        assign slot[n].ppu_wr      = ppu_wr;

        if (n == 0) begin : g_empty
            // no mapper so nothing is ever enabled
            assign prg_addr_v[n]  = '0;
            assign chr_addr_v[n]  = '0;
            assign prg_oe_v[n]    = 1'b0;
            assign chr_ce_v[n]    = 1'b0;
            assign chr_oe_v[n]    = 1'b0;
            assign chr_we_v[n]    = 1'b0;
            assign ciram_a10_v[n] = 1'b0;
            assign ciram_ce_v[n]  = 1'b0;
            assign irq_v[n]       = 1'b0;
        end else begin : g_used
            assign prg_addr_v[n]  = slot[n].prg_addr;
            assign chr_addr_v[n]  = slot[n].chr_addr;
            assign prg_oe_v[n]    = slot[n].prg_oe;
            assign chr_ce_v[n]    = slot[n].chr_ce;
            assign chr_oe_v[n]    = slot[n].chr_oe;
            assign chr_we_v[n]    = slot[n].chr_we;
            assign ciram_a10_v[n] = slot[n].ciram_a10;
            assign ciram_ce_v[n]  = slot[n].ciram_ce;
            assign irq_v[n]       = slot[n].irq;
        end
    end

    //////////////////////////////////////////////////
    // active slot outputs
    //////////////////////////////////////////////////

    // PRG size is a power of two mirrored over the whole window
    assign prg_mask = (args.prg_log2 == 5'd0) ? '1
                    : prg_addr_t'((32'd1 << args.prg_log2) - 32'd1);

    assign cpu_oe    = prg_oe_v[select];
    assign ppu_oe    = chr_ce_v[select] && chr_oe_v[select];
    assign irq       = irq_v[select];
    assign ciram_a10 = ciram_a10_v[select];
    assign ciram_ce  = ciram_ce_v[select];

    assign prg.addr  = prg_addr_v[select] & prg_mask;
    assign prg.oe    = cpu_oe;
    assign prg.we    = 1'b0;
    assign prg.wdata = cpu_data_in;

    assign chr.addr  = chr_addr_v[select];
    assign chr.oe    = ppu_oe;
    assign chr.we    = chr_we_v[select];
    assign chr.wdata = ppu_data_in;

    // the CPU data pins must never drive during a CPU write cycle
    a_oe_rw: assert final (!(cpu_oe && !cpu_rw))
        else $error("map_mux: cpu_oe high during a write");

endmodule

`default_nettype wire

// ==== discrete_mapper.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cart_defs.svh"

module discrete_mapper #(
    parameter cart_pkg::mapper_id_t kind = cart_pkg::map_nrom
) (
    input logic    m2,
    map_bus.mapper bus
);
    import cart_pkg::*;
    import mem_pkg::*;

    logic [`PRG_BANK_BITS-1:0] bank;
    logic                      bank_wr;

    // any CPU write to 8000-FFFF hits the bank latch
    assign bank_wr = !bus.cpu_rw && bus.cpu_addr[15];

    always_ff @(posedge m2 or posedge bus.reset) begin
        if (bus.reset) begin
            bank <= '0;
        end else if (bank_wr) begin
            bank <= bus.cpu_data_in[`PRG_BANK_BITS-1:0];
        end
    end

    //////////////////////////////////////////////////
    // address translation
    //////////////////////////////////////////////////

    always_comb begin
        bus.prg_addr = prg_addr_t'(bus.cpu_addr[14:0]);
        bus.chr_addr = chr_addr_t'(bus.ppu_addr[12:0]);
        case (kind)
            map_uxrom: begin
                if (bus.cpu_addr[14]) begin
                    // the size mask turns the fixed upper window into the last bank
                    bus.prg_addr = {{(`PRG_ADDR_BITS-14){1'b1}}, bus.cpu_addr[13:0]};
                end else begin
                    bus.prg_addr = prg_addr_t'({bank, bus.cpu_addr[13:0]});
                end
            end
            map_cnrom: begin
                bus.chr_addr = chr_addr_t'({bank[`CHR_BANK_BITS-1:0], bus.ppu_addr[12:0]});
            end
            default: begin
            end
        endcase
    end

    // strobes
    assign bus.prg_oe    = bus.cpu_rw && bus.cpu_addr[15];
    assign bus.chr_ce    = !bus.ppu_addr[13];
    assign bus.chr_oe    = bus.ppu_rd;
    assign bus.chr_we    = (kind == map_uxrom) && bus.ppu_wr && !bus.ppu_addr[13];
    assign bus.ciram_ce  = bus.ppu_addr[13];
    assign bus.ciram_a10 = (bus.args.mirror == mirror_vert) ? bus.ppu_addr[10]
                                                             : bus.ppu_addr[11];
    assign bus.irq       = 1'b0;

    // CHR RAM has a single data path
    a_chr_rw_excl: assert property (
        @(posedge m2) disable iff (bus.reset) !(bus.chr_we && bus.chr_oe)
    ) else $error("discrete_mapper: chr_we and chr_oe both high");

endmodule

`default_nettype wire

// ==== map_config.sv ====
`timescale 1ns/100ps
`default_nettype none

module map_config (
    input  logic                   m2,
    input  logic                   async_reset,
    input  logic [31:0]            wr_reg,
    input  logic [3:0]             wr_reg_addr,
    input  logic                   wr_reg_changed,
    output cart_pkg::mapper_id_t   select,
    output cart_pkg::map_args_t    args
);
    import cart_pkg::*;

    // two sync stages and a third that holds the previous level
    logic [2:0] chg_sync;
    logic       chg_seen;

    assign chg_seen = chg_sync[2] ^ chg_sync[1];

    always_ff @(posedge m2 or posedge async_reset) begin
        if (async_reset) begin
            chg_sync <= '0;
            select   <= map_none;
            args     <= '0;
        end else begin
            chg_sync <= {chg_sync[1:0], wr_reg_changed};
            // only register 0 carries the mapper config
            if (chg_seen && wr_reg_addr == 4'd0) begin
                select <= mapper_id_t'(wr_reg[1:0]);
                args   <= map_args_t'(wr_reg[8:2]);
            end
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // a stale or undriven config word must not leak into the slot select
    a_select_known: assert property (
        @(posedge m2) disable iff (async_reset) !$isunknown(select)
    ) else $error("map_config: select is unknown");

endmodule

`default_nettype wire

// ==== cart_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// one instance per mapper slot
interface map_bus;
    import cart_pkg::*;
    import mem_pkg::*;

    // driven by the mux
    logic        reset;
    map_args_t   args;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_data_in;
    logic        cpu_rw;
    logic [13:0] ppu_addr;
    logic        ppu_rd;
    logic        ppu_wr;

    // driven by the mapper
    prg_addr_t   prg_addr;
    logic        prg_oe;
    chr_addr_t   chr_addr;
    logic        chr_ce;
    logic        chr_oe;
    logic        chr_we;
    logic        ciram_a10;
    logic        ciram_ce;
    logic        irq;

    modport mux (
        output reset, args, cpu_addr, cpu_data_in, cpu_rw, ppu_addr, ppu_rd, ppu_wr,
        input  prg_addr, prg_oe, chr_addr, chr_ce, chr_oe, chr_we, ciram_a10, ciram_ce, irq
    );

    modport mapper (
        input  reset, args, cpu_addr, cpu_data_in, cpu_rw, ppu_addr, ppu_rd, ppu_wr,
        output prg_addr, prg_oe, chr_addr, chr_ce, chr_oe, chr_we, ciram_a10, ciram_ce, irq
    );
endinterface

// memory channel port used once for PRG and once for CHR
interface mem_bus #(
    parameter type addr_t = mem_pkg::prg_addr_t
);
    addr_t      addr;
    logic       oe;
    logic       we;
    logic [7:0] wdata;
    logic [7:0] rdata;

    modport client (output addr, oe, we, wdata, input rdata);
    modport channel (input addr, oe, we, wdata, output rdata);
endinterface

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

`include "cart_defs.svh"

package mem_pkg;

    //////////////////////////////////////////////////
    // memory addresses
    //////////////////////////////////////////////////

    typedef logic [`PRG_ADDR_BITS-1:0] prg_addr_t;
    typedef logic [`CHR_ADDR_BITS-1:0] chr_addr_t;

    // host load request carrying one byte per cycle
    typedef struct packed {
        logic                      we;
        logic                      chr;    // 1 targets the CHR array
        logic [`PRG_ADDR_BITS-1:0] addr;
        logic [7:0]                data;
    } load_req_t;

endpackage

`default_nettype wire

// ==== cart_pkg.sv ====
`default_nettype none

package cart_pkg;

    //////////////////////////////////////////////////
    // mapper selection
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        map_none  = 2'd0,
        map_nrom  = 2'd1,
        map_uxrom = 2'd2,
        map_cnrom = 2'd3
    } mapper_id_t;

    // nametable mirroring
    typedef enum logic {
        mirror_horz = 1'b0,
        mirror_vert = 1'b1
    } mirror_t;

    // prg_log2 sits in the low bits of the config word
    typedef struct packed {
        logic       spare;
        mirror_t    mirror;
        logic [4:0] prg_log2;   // 0 leaves PRG unmasked
    } map_args_t;

endpackage

`default_nettype wire

// ==== cart_defs.svh ====
`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

// memory address widths for 512 KiB of PRG
`define PRG_ADDR_BITS 19
`define CHR_ADDR_BITS 17

// slot 0 is the empty slot
`define MAP_CNT 4

// bank register widths
`define PRG_BANK_BITS 4
`define CHR_BANK_BITS 2

`endif
